//--- verification/rename_stimulus.txt
# in: uop upd src1 src2 dest, ring upd tag value, commit upd arch phys free, rollback
# out after edge: src1 tag value rdy, src2 tag value rdy, dest_phys dest_oldphys none_free
0 0 0 0 0 00 00000000 0 0 00 00 0  00 00000000 0 00 00000000 0 00 00 0
1 4 5 1 0 00 00000000 0 0 00 00 0  00 00000000 0 00 00000000 0 00 00 0
1 6 7 2 0 00 00000000 0 0 00 00 0  04 00000000 1 05 00000000 1 10 01 0
1 8 9 3 0 00 00000000 0 0 00 00 0  06 00000000 1 07 00000000 1 11 02 0
0 0 0 0 0 00 00000000 0 0 00 00 0  08 00000000 1 09 00000000 1 12 03 0
1 1 2 4 0 00 00000000 0 0 00 00 0  08 00000000 1 09 00000000 1 12 03 0
0 0 0 0 1 10 deadbeef 0 0 00 00 0  10 00000000 0 11 00000000 0 13 04 0
1 1 3 5 0 00 00000000 0 0 00 00 0  10 00000000 0 11 00000000 0 13 04 0
0 0 0 0 1 11 0000abcd 0 0 00 00 0  10 deadbeef 1 12 00000000 0 14 05 0
0 0 0 0 1 12 12345678 0 0 00 00 0  10 deadbeef 1 12 00000000 0 14 05 0
1 2 3 6 0 00 00000000 0 0 00 00 0  10 deadbeef 1 12 00000000 0 14 05 0
0 0 0 0 0 00 00000000 0 0 00 00 0  11 0000abcd 1 12 12345678 1 15 06 0
1 0 0 7 0 00 00000000 0 0 00 00 0  11 0000abcd 1 12 12345678 1 15 06 0
1 7 0 8 0 00 00000000 0 0 00 00 0  00 00000000 1 00 00000000 1 16 07 0
1 8 7 9 0 00 00000000 0 0 00 00 0  16 00000000 0 00 00000000 1 17 08 0
1 9 9 a 0 00 00000000 0 0 00 00 0  17 00000000 0 16 00000000 0 18 09 0
1 a 1 b 0 00 00000000 0 0 00 00 0  18 00000000 0 18 00000000 0 19 0a 0
1 b 2 c 0 00 00000000 0 0 00 00 0  19 00000000 0 10 deadbeef 1 1a 0b 0
1 c 3 d 0 00 00000000 0 0 00 00 0  1a 00000000 0 11 0000abcd 1 1b 0c 0
1 d 0 e 0 00 00000000 0 0 00 00 0  1b 00000000 0 12 12345678 1 1c 0d 0
1 e 0 f 0 00 00000000 0 0 00 00 0  1c 00000000 0 00 00000000 1 1d 0e 0
1 f 0 0 0 00 00000000 0 0 00 00 0  1d 00000000 0 00 00000000 1 1e 0f 1
1 1 2 3 0 00 00000000 0 0 00 00 0  1e 00000000 0 00 00000000 1 1f 00 1
0 0 0 0 0 00 00000000 0 0 00 00 0  1e 00000000 0 00 00000000 1 1f 00 1
0 0 0 0 0 00 00000000 1 1 10 01 0  1e 00000000 0 00 00000000 1 1f 00 0
1 1 2 3 0 00 00000000 0 0 00 00 0  1e 00000000 0 00 00000000 1 1f 00 1
0 0 0 0 0 00 00000000 0 0 00 00 0  10 deadbeef 1 11 0000abcd 1 01 12 1
0 0 0 0 0 00 00000000 1 2 11 02 0  10 deadbeef 1 11 0000abcd 1 01 12 0
1 3 4 5 0 00 00000000 0 0 00 00 0  10 deadbeef 1 11 0000abcd 1 01 12 1
0 0 0 0 1 01 00000055 0 0 00 00 0  01 00000000 0 13 00000000 0 02 14 1
0 0 0 0 0 00 00000000 1 4 13 04 0  01 00000000 0 13 00000000 0 02 14 0
0 0 0 0 0 00 00000000 0 0 00 00 1  01 00000000 0 13 00000000 0 02 14 0
1 1 4 3 0 00 00000000 0 0 00 00 0  01 00000000 0 13 00000000 0 02 14 0
1 3 2 6 0 00 00000000 0 0 00 00 0  10 deadbeef 1 13 00000000 1 01 03 0
1 0 5 7 0 00 00000000 0 0 00 00 0  01 00000055 0 11 0000abcd 1 02 06 0
0 0 0 0 0 00 00000000 0 0 00 00 0  00 00000000 1 05 00000000 1 04 07 0
0 0 0 0 1 04 0badf00d 0 0 00 00 0  00 00000000 1 05 00000000 1 04 07 0
1 7 6 8 0 00 00000000 0 0 00 00 0  00 00000000 1 05 00000000 1 04 07 0
0 0 0 0 0 00 00000000 0 0 00 00 0  04 0badf00d 1 02 00000000 0 12 08 0
0 0 0 0 1 02 00000777 0 0 00 00 0  04 0badf00d 1 02 00000000 0 12 08 0
1 6 3 9 0 00 00000000 0 0 00 00 0  04 0badf00d 1 02 00000000 0 12 08 0
0 0 0 0 0 00 00000000 0 0 00 00 0  02 00000777 1 01 00000055 0 14 09 0

//--- sim.f
hdl/rename_pkg.sv
hdl/arch_map_table.sv
hdl/free_list.sv
hdl/phys_value_file.sv
hdl/phys_regfile.sv
hdl/rename_regfile.sv
verification/rename_regfile_checker.sv
verification/rename_regfile_tb.sv

//--- verification/rename_regfile_tb.sv
`timescale 1ns/1ns

module rename_regfile_tb;

    import rename_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 4;
    localparam int SEED = 53;
    // idle cycles spread between vectors, bounded by the watchdog margin
    localparam int MAX_GAPS = 10;
    localparam string STIM_FILE = "verification/rename_stimulus.txt";

    // inputs of one cycle and the outputs expected after its edge
    typedef struct packed {
        uop_req_t    uop;
        ring_wr_t    ring;
        rob_commit_t commit;
        logic        rollback;
        src_read_t   src1;
        src_read_t   src2;
        phys_tag_t   dest_phys;
        phys_tag_t   dest_oldphys;
        logic        none_free;
    } vector_t;

    logic        clk;
    logic        rst_n;
    uop_req_t    uop;
    ring_wr_t    ring;
    rob_commit_t commit;
    logic        rollback;
    src_read_t   src1;
    src_read_t   src2;
    phys_tag_t   dest_phys;
    phys_tag_t   dest_oldphys;
    logic        none_free;

    vector_t vectors[$];
    int      errors = 0;
    int      checks = 0;
    int      gaps = 0;
    logic    loaded = 1'b0;

    rename_regfile dut0 (
        .clk(clk), .rst_n(rst_n), .uop(uop), .ring(ring), .commit(commit),
        .rollback(rollback), .src1(src1), .src2(src2), .dest_phys(dest_phys),
        .dest_oldphys(dest_oldphys), .none_free(none_free)
    );

    bind phys_regfile rename_regfile_checker chk0 (
        .clk(clk), .rst_n(rst_n), .ring(ring), .next_free(next_free),
        .none_free(none_free), .committed_used(committed_used), .free_vec(fl0.free_vec)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [21];
        vector_t     v;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line,
                "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
            if (n != 21) begin
                $display("stimulus line has %0d fields instead of 21: %s", n, line);
                errors++;
                continue;
            end
            v.uop.update = f[0][0];
            v.uop.src1 = arch_tag_t'(f[1]);
            v.uop.src2 = arch_tag_t'(f[2]);
            v.uop.dest = arch_tag_t'(f[3]);
            v.ring.update = f[4][0];
            v.ring.tag = phys_tag_t'(f[5]);
            v.ring.value = f[6];
            v.commit.update = f[7][0];
            v.commit.arch = arch_tag_t'(f[8]);
            v.commit.phys = phys_tag_t'(f[9]);
            v.commit.free_tag = phys_tag_t'(f[10]);
            v.rollback = f[11][0];
            v.src1 = '{tag: phys_tag_t'(f[12]), value: f[13], rdy: f[14][0]};
            v.src2 = '{tag: phys_tag_t'(f[15]), value: f[16], rdy: f[17][0]};
            v.dest_phys = phys_tag_t'(f[18]);
            v.dest_oldphys = phys_tag_t'(f[19]);
            v.none_free = f[20][0];
            vectors.push_back(v);
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("no stimulus vectors were read from %s", STIM_FILE);
            errors++;
        end
    endtask

    task automatic drive_vector(input vector_t v);
        uop = v.uop;
        ring = v.ring;
        commit = v.commit;
        rollback = v.rollback;
    endtask

    task automatic drive_idle();
        uop = '0;
        ring = '0;
        commit = '0;
        rollback = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_outputs(input int idx, input vector_t v);
        string name;
        name = $sformatf("vector %0d", idx);
        check_value({name, " src1.tag"}, v.src1.tag, src1.tag);
        check_value({name, " src1.value"}, v.src1.value, src1.value);
        check_value({name, " src1.rdy"}, v.src1.rdy, src1.rdy);
        check_value({name, " src2.tag"}, v.src2.tag, src2.tag);
        check_value({name, " src2.value"}, v.src2.value, src2.value);
        check_value({name, " src2.rdy"}, v.src2.rdy, src2.rdy);
        check_value({name, " dest_phys"}, v.dest_phys, dest_phys);
        check_value({name, " dest_oldphys"}, v.dest_oldphys, dest_oldphys);
        check_value({name, " none_free"}, v.none_free, none_free);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        drive_idle();
        load_vectors();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (vectors[i]) begin
            drive_vector(vectors[i]);
            @(negedge clk);
            check_outputs(i, vectors[i]);
            // gaps only after vectors without a micro-op keep each read on its vector
            if (!vectors[i].uop.update && gaps < MAX_GAPS && ($urandom % 4) == 0) begin
                drive_idle();
                @(negedge clk);
                gaps++;
            end
        end
        errors += dut0.prf0.chk0.failures;
        $display("checks %0d, errors %0d, idle gaps %0d", checks, errors, gaps);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #((vectors.size() + 20) * CLK_PERIOD);
        $display("timeout: stimulus replay did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- verification/rename_regfile_checker.sv
`timescale 1ns/1ns

module rename_regfile_checker (
    input logic                              clk,
    input logic                              rst_n,
    input rename_pkg::ring_wr_t              ring,
    input rename_pkg::phys_tag_t             next_free,
    input logic                              none_free,
    input logic [rename_pkg::PHYS_REGS-1:0]  committed_used,
    input logic [rename_pkg::PHYS_REGS-1:0]  free_vec
);

    int failures = 0;

    // results only land in registers that rename has handed out
    ring_not_free: assert property (@(posedge clk) disable iff (!rst_n)
        ring.update |-> !free_vec[ring.tag])
    else begin
        $error("ring write to free physical register %0d", ring.tag);
        failures++;
    end

    // search result is free unless the whole vector is empty
    none_free_matches: assert property (@(posedge clk) disable iff (!rst_n)
        none_free != free_vec[next_free])
    else begin
        $error("none_free %0b disagrees with free vector %h at next free %0d",
               none_free, free_vec, next_free);
        failures++;
    end

    // free and committed sets never overlap
    next_free_unused: assert property (@(posedge clk) disable iff (!rst_n)
        !none_free |-> !committed_used[next_free])
    else begin
        $error("next free register %0d is committed", next_free);
        failures++;
    end

endmodule

//--- hdl/rename_regfile.sv
`timescale 1ns/1ns

module rename_regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rename_pkg::uop_req_t    uop,
    input  rename_pkg::ring_wr_t    ring,
    input  rename_pkg::rob_commit_t commit,
    input  logic                    rollback,
    output rename_pkg::src_read_t   src1,
    output rename_pkg::src_read_t   src2,
    output rename_pkg::phys_tag_t   dest_phys,
    output rename_pkg::phys_tag_t   dest_oldphys,
    output logic                    none_free
);

    import rename_pkg::*;

    logic      accept;
    logic      accept_d;
    phys_tag_t next_free;
    phys_tag_t map_src1;
    phys_tag_t map_src2;
    phys_tag_t map_old;

    // stage register between lookup and value read
    phys_tag_t stg_src1;
    phys_tag_t stg_src2;
    phys_tag_t stg_dest;
    phys_tag_t stg_old;

    // a micro-op with no free register is dropped
    assign accept = uop.update & ~none_free;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            accept_d <= 1'b0;
        end else begin
            accept_d <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stg_src1 <= map_src1;
            stg_src2 <= map_src2;
            stg_dest <= next_free;
            stg_old <= map_old;
        end
    end

    // destination tags appear with the source reads
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dest_phys <= '0;
            dest_oldphys <= '0;
        end else if (accept_d) begin
            dest_phys <= stg_dest;
            dest_oldphys <= stg_old;
        end
    end

    arch_map_table amt0 (
        .clk(clk), .rst_n(rst_n), .accept(accept), .uop(uop), .new_phys(next_free),
        .commit(commit), .rollback(rollback),
        .src1_phys(map_src1), .src2_phys(map_src2), .dest_oldphys(map_old)
    );

    phys_regfile prf0 (
        .clk(clk), .rst_n(rst_n), .accept(accept), .accept_d(accept_d),
        .rd1_tag(stg_src1), .rd2_tag(stg_src2), .wr_tag(stg_dest),
        .ring(ring), .commit(commit), .rollback(rollback),
        .src1(src1), .src2(src2), .next_free(next_free), .none_free(none_free)
    );

endmodule

//--- hdl/phys_regfile.sv
`timescale 1ns/1ns

module phys_regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    accept,
    input  logic                    accept_d,
    input  rename_pkg::phys_tag_t   rd1_tag,
    input  rename_pkg::phys_tag_t   rd2_tag,
    input  rename_pkg::phys_tag_t   wr_tag,
    input  rename_pkg::ring_wr_t    ring,
    input  rename_pkg::rob_commit_t commit,
    input  logic                    rollback,
    output rename_pkg::src_read_t   src1,
    output rename_pkg::src_read_t   src2,
    output rename_pkg::phys_tag_t   next_free,
    output logic                    none_free
);

    import rename_pkg::*;

    logic [PHYS_REGS-1:0] committed_used;
    phys_tag_t            tag1_q;
    phys_tag_t            tag2_q;
    data_t                val1;
    data_t                val2;
    logic                 rdy1;
    logic                 rdy2;

    // tags line up with the registered read data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag1_q <= '0;
            tag2_q <= '0;
        end else if (accept_d) begin
            tag1_q <= rd1_tag;
            tag2_q <= rd2_tag;
        end
    end

    assign src1 = '{tag: tag1_q, value: val1, rdy: rdy1};
    assign src2 = '{tag: tag2_q, value: val2, rdy: rdy2};

    phys_value_file pvf0 (
        .clk(clk), .rst_n(rst_n),
        .rd1_tag(rd1_tag), .rd2_tag(rd2_tag),
        .clear_tag(wr_tag), .clear_en(accept_d),
        .ring(ring), .rollback(rollback), .committed_used(committed_used),
        .rd1_val(val1), .rd2_val(val2), .rd1_rdy(rdy1), .rd2_rdy(rdy2)
    );

    free_list fl0 (
        .clk(clk), .rst_n(rst_n), .accept(accept), .commit(commit), .rollback(rollback),
        .next_free(next_free), .none_free(none_free), .committed_used(committed_used)
    );

endmodule

//--- hdl/phys_value_file.sv
`timescale 1ns/1ns

module phys_value_file (
    input  logic                               clk,
    input  logic                               rst_n,
    input  rename_pkg::phys_tag_t              rd1_tag,
    input  rename_pkg::phys_tag_t              rd2_tag,
    input  rename_pkg::phys_tag_t              clear_tag,
    input  logic                               clear_en,
    input  rename_pkg::ring_wr_t               ring,
    input  logic                               rollback,
    input  logic [rename_pkg::PHYS_REGS-1:0]   committed_used,
    output rename_pkg::data_t                  rd1_val,
    output rename_pkg::data_t                  rd2_val,
    output logic                               rd1_rdy,
    output logic                               rd2_rdy
);

    import rename_pkg::*;

    data_t                vals [PHYS_REGS];
    logic [PHYS_REGS-1:0] rdy_vec;
    logic [PHYS_REGS-1:0] rdy_nxt;

    // ring sets after the clear, rollback last
    always_comb begin
        rdy_nxt = rdy_vec;
        if (clear_en) begin
            rdy_nxt[clear_tag] = 1'b0;
        end
        if (ring.update) begin
            rdy_nxt[ring.tag] = 1'b1;
        end
        if (rollback) begin
            rdy_nxt = rdy_nxt | committed_used;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                vals[i] <= '0;
            end
            rdy_vec <= RESET_USED;
        end else begin
            rdy_vec <= rdy_nxt;
            if (ring.update) begin
                vals[ring.tag] <= ring.value;
            end
        end
    end

    // read ports load together with the clear of the new destination,
    // so a ring write at the same edge is not seen
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd1_val <= '0;
            rd2_val <= '0;
            rd1_rdy <= 1'b0;
            rd2_rdy <= 1'b0;
        end else if (clear_en) begin
            rd1_val <= vals[rd1_tag];
            rd2_val <= vals[rd2_tag];
            rd1_rdy <= rdy_vec[rd1_tag];
            rd2_rdy <= rdy_vec[rd2_tag];
        end
    end

endmodule

//--- hdl/free_list.sv
`timescale 1ns/1ns

module free_list (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               accept,
    input  rename_pkg::rob_commit_t            commit,
    input  logic                               rollback,
    output rename_pkg::phys_tag_t              next_free,
    output logic                               none_free,
    output logic [rename_pkg::PHYS_REGS-1:0]   committed_used
);

    import rename_pkg::*;

    logic [PHYS_REGS-1:0] free_vec;
    logic [PHYS_REGS-1:0] free_nxt;
    logic [PHYS_REGS-1:0] used_nxt;

    // lowest set bit wins
    always_comb begin
        next_free = '0;
        for (int i = PHYS_REGS - 1; i >= 0; i--) begin
            if (free_vec[i]) begin
                next_free = phys_tag_t'(i);
            end
        end
    end

    assign none_free = ~|free_vec;

    always_comb begin
        free_nxt = free_vec;
        used_nxt = committed_used;
        if (rollback) begin
            free_nxt = ~committed_used;
        end else begin
            if (accept) begin
                free_nxt[next_free] = 1'b0;
            end
            if (commit.update) begin
                // retired mapping becomes committed, the one it replaced goes back
                free_nxt[commit.free_tag] = 1'b1;
                used_nxt[commit.phys] = 1'b1;
                used_nxt[commit.free_tag] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_vec <= ~RESET_USED;
            committed_used <= RESET_USED;
        end else begin
            free_vec <= free_nxt;
            committed_used <= used_nxt;
        end
    end

endmodule

//--- hdl/arch_map_table.sv
`timescale 1ns/1ns

module arch_map_table (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    accept,
    input  rename_pkg::uop_req_t    uop,
    input  rename_pkg::phys_tag_t   new_phys,
    input  rename_pkg::rob_commit_t commit,
    input  logic                    rollback,
    output rename_pkg::phys_tag_t   src1_phys,
    output rename_pkg::phys_tag_t   src2_phys,
    output rename_pkg::phys_tag_t   dest_oldphys
);

    import rename_pkg::*;

    // speculative map, updated at rename
    phys_tag_t spec_map [ARCH_REGS];
    // committed map, updated at retire
    phys_tag_t com_map [ARCH_REGS];

    // lookups see the map before this edge's rename
    assign src1_phys = spec_map[uop.src1];
    assign src2_phys = spec_map[uop.src2];
    assign dest_oldphys = spec_map[uop.dest];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i] <= phys_tag_t'(i);
            end
        end else if (rollback) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i] <= com_map[i];
            end
        end else if (accept) begin
            spec_map[uop.dest] <= new_phys;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                com_map[i] <= phys_tag_t'(i);
            end
        end else if (commit.update && !rollback) begin
            // rollback takes the whole edge, a commit beside it is dropped
            com_map[commit.arch] <= commit.phys;
        end
    end

endmodule

//--- hdl/rename_pkg.sv
package rename_pkg;

    localparam int ARCH_REGS = 16;
    localparam int PHYS_REGS = 32;
    localparam int DATA_W = 32;
    localparam int ARCH_W = $clog2(ARCH_REGS);
    localparam int PHYS_W = $clog2(PHYS_REGS);

    // low physical registers carry the committed state out of reset
    localparam logic [PHYS_REGS-1:0] RESET_USED =
        {{(PHYS_REGS - ARCH_REGS){1'b0}}, {ARCH_REGS{1'b1}}};

    typedef logic [ARCH_W-1:0] arch_tag_t;
    typedef logic [PHYS_W-1:0] phys_tag_t;
    typedef logic [DATA_W-1:0] data_t;

    // one micro-op from rename
    typedef struct packed {
        logic      update;
        arch_tag_t src1;
        arch_tag_t src2;
        arch_tag_t dest;
    } uop_req_t;

    // result ring write
    typedef struct packed {
        logic      update;
        phys_tag_t tag;
        data_t     value;
    } ring_wr_t;

    // reorder buffer commit
    typedef struct packed {
        logic      update;
        arch_tag_t arch;
        phys_tag_t phys;
        phys_tag_t free_tag;
    } rob_commit_t;

    typedef struct packed {
        phys_tag_t tag;
        data_t     value;
        logic      rdy;
    } src_read_t;

endpackage
